/* Makefile */
VERILATOR ?= verilator
TOP       := tb_cpu_backend
FILE_LIST := all.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
verilog/cpu_pkg.sv
verilog/op_queue.sv
verilog/register_file.sv
verilog/forwarding_unit.sv
verilog/ex_stage.sv
verilog/mem_wb_stage.sv
verilog/cpu_backend.sv
testbench/tb_clock_gen.sv
testbench/tb_cpu_backend.sv

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* testbench/tb_cpu_backend.sv */
`timescale 1ns/1ps

module tb_cpu_backend
    import cpu_pkg::*;
();

    localparam int NUM_OPS        = 400;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 8 + 200;
    localparam int DRAIN_CYCLES   = 8;

    logic  clk;
    logic  rst_n;
    logic  op_valid;
    op_t   op;
    logic  credit_return;
    logic  wb_valid;
    wb_t   wb;

    word_t       model_regs [REG_COUNT];
    word_t       model_mem [DMEM_DEPTH];
    wb_t         expected_q [$];
    logic [31:0] rng;
    logic [31:0] r1;
    logic [31:0] r2;
    op_t         next_op;
    int          credits;
    int          sent;
    int          cycles;
    int          gap;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cpu_backend u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .op_valid      (op_valid),
        .op            (op),
        .credit_return (credit_return),
        .wb_valid      (wb_valid),
        .wb            (wb)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t model_alu(input alu_op_t fn, input word_t a, input word_t b);
        case (fn)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sll: return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    // registers 0-7 only, so hazards show up often
    function automatic op_t make_op(input logic [31:0] a, input logic [31:0] b);
        op_t o;
        o.kind   = op_kind_t'(a[1:0]);
        o.alu_op = alu_op_t'(a[4:2]);
        o.rs     = {2'b00, a[7:5]};
        o.rt     = {2'b00, a[10:8]};
        o.rd     = {2'b00, a[13:11]};
        if (o.kind == load || o.kind == store) begin
            if (a[14]) begin
                // base r0 and a few addresses, so loads hit earlier stores
                o.rs  = '0;
                o.imm = {28'd0, b[3:0]};
            end else begin
                o.imm = {26'd0, b[5:0]};
            end
        end else if (a[15]) begin
            o.imm = {27'd0, b[4:0]};
        end else begin
            o.imm = b;
        end
        return o;
    endfunction

    task automatic model_step(input op_t o);
        word_t a;
        word_t b;
        word_t addr;
        wb_t   exp;
        a    = model_regs[o.rs];
        b    = (o.kind == alu_reg) ? model_regs[o.rt] : o.imm;
        addr = a + o.imm;
        if (o.kind == store) begin
            model_mem[addr[DMEM_ADDR_WIDTH-1:0]] = model_regs[o.rt];
        end else begin
            exp.rd = o.rd;
            if (o.kind == load) begin
                exp.data = model_mem[addr[DMEM_ADDR_WIDTH-1:0]];
            end else begin
                exp.data = model_alu(o.alu_op, a, b);
            end
            expected_q.push_back(exp);
            // r0 reports but keeps reading zero
            if (o.rd != '0) begin
                model_regs[o.rd] = exp.data;
            end
        end
    endtask

    task automatic fail_run(input string reason);
        $display("Simulation failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_wb_rd(input string name, input reg_idx_t expected,
                               input reg_idx_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, expected, actual);
            fail_run("write-back register index mismatch");
        end
    endtask

    task automatic check_wb_data(input string name, input word_t expected,
                                 input word_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, expected, actual);
            fail_run("write-back data mismatch");
        end
    endtask

    task automatic check_credits(input string name, input logic [CREDIT_WIDTH-1:0] expected,
                                 input logic [CREDIT_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, expected, actual);
            fail_run("credit count mismatch");
        end
    endtask

    task automatic check_write_back();
        wb_t exp;
        if (expected_q.size() == 0) begin
            fail_run("write-back arrived with no operation outstanding");
        end else begin
            exp = expected_q.pop_front();
            check_wb_rd("wb.rd", exp.rd, wb.rd);
            check_wb_data("wb.data", exp.data, wb.data);
        end
    endtask

    initial begin
        op_valid = 1'b0;
        op       = '0;
        rng      = 32'h9d2;
        credits  = QUEUE_DEPTH;
        sent     = 0;
        cycles   = 0;
        gap      = 0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        foreach (model_mem[i]) begin
            model_mem[i] = '0;
        end

        while (rst_n !== 1'b1) begin
            @(posedge clk);
        end

        // one process samples, checks and drives, all on the rising edge
        while (sent < NUM_OPS || expected_q.size() != 0 || credits != QUEUE_DEPTH) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_run("timeout waiting for write-back");
            end
            if (wb_valid) begin
                check_write_back();
            end
            if (credit_return) begin
                if (credits >= QUEUE_DEPTH) begin
                    fail_run("credit returned with no operation outstanding");
                end
                credits++;
            end
            if (sent < NUM_OPS && gap == 0 && credits > 0) begin
                rng     = xorshift32(rng);
                r1      = rng;
                rng     = xorshift32(rng);
                r2      = rng;
                next_op = make_op(r1, r2);
                op_valid <= 1'b1;
                op       <= next_op;
                model_step(next_op);
                credits--;
                sent++;
                gap = {30'd0, r1[17:16]};
            end else begin
                op_valid <= 1'b0;
                if (gap > 0) begin
                    gap--;
                end
            end
        end

        // pipeline must stay quiet once everything is back
        repeat (DRAIN_CYCLES) begin
            @(posedge clk);
            if (wb_valid) begin
                fail_run("write-back after the last operation completed");
            end
            if (credit_return) begin
                credits++;
            end
            check_credits("credits", CREDIT_WIDTH'(QUEUE_DEPTH), CREDIT_WIDTH'(credits));
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* verilog/cpu_backend.sv */
`timescale 1ns/1ps

module cpu_backend
    import cpu_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic op_valid,
    input  op_t  op,
    output logic credit_return,
    output logic wb_valid,
    output wb_t  wb
);

    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_data;
    word_t    rt_data;

    ex_fwd_t  ex_fwd;
    logic     issue;
    op_t      issued_op;
    word_t    issued_rs_data;
    word_t    issued_rt_data;

    fwd_sel_t a_sel;
    fwd_sel_t b_sel;
    fwd_sel_t store_sel;

    dest_t    mem_dest;
    logic     mem_is_load;
    logic     mem_is_store;
    word_t    mem_addr;
    word_t    mem_store_data;
    dest_t    wb_dest;

    op_queue op_queue (
        .clk            (clk),
        .rst_n          (rst_n),
        .op_valid       (op_valid),
        .op             (op),
        .credit_return  (credit_return),
        .rs_idx         (rs_idx),
        .rt_idx         (rt_idx),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .ex_fwd         (ex_fwd),
        .issue          (issue),
        .issued_op      (issued_op),
        .issued_rs_data (issued_rs_data),
        .issued_rt_data (issued_rt_data)
    );

    register_file register_file (
        .clk            (clk),
        .rst_n          (rst_n),
        .rs_idx         (rs_idx),
        .rt_idx         (rt_idx),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .wb_dest        (wb_dest)
    );

    forwarding_unit forwarding_unit (
        .ex_fwd         (ex_fwd),
        .mem_dest       (mem_dest),
        .wb_dest        (wb_dest),
        .a_sel          (a_sel),
        .b_sel          (b_sel),
        .store_sel      (store_sel)
    );

    ex_stage ex_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue          (issue),
        .issued_op      (issued_op),
        .issued_rs_data (issued_rs_data),
        .issued_rt_data (issued_rt_data),
        .a_sel          (a_sel),
        .b_sel          (b_sel),
        .store_sel      (store_sel),
        .wb_dest        (wb_dest),
        .ex_fwd         (ex_fwd),
        .mem_dest       (mem_dest),
        .mem_is_load    (mem_is_load),
        .mem_is_store   (mem_is_store),
        .mem_addr       (mem_addr),
        .mem_store_data (mem_store_data)
    );

    mem_wb_stage mem_wb_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_dest       (mem_dest),
        .mem_is_load    (mem_is_load),
        .mem_is_store   (mem_is_store),
        .mem_addr       (mem_addr),
        .mem_store_data (mem_store_data),
        .wb_dest        (wb_dest),
        .wb_valid       (wb_valid),
        .wb             (wb)
    );

endmodule

/* verilog/cpu_pkg.sv */
package cpu_pkg;

    localparam int WORD_WIDTH      = 32;
    localparam int REG_IDX_WIDTH   = 5;
    localparam int REG_COUNT       = 2 ** REG_IDX_WIDTH;
    localparam int SHAMT_WIDTH     = 5;
    localparam int DMEM_DEPTH      = 64;
    localparam int DMEM_ADDR_WIDTH = $clog2(DMEM_DEPTH);
    localparam int QUEUE_DEPTH     = 4;
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int CREDIT_WIDTH    = 3;

    typedef logic [WORD_WIDTH-1:0]    word_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl
    } alu_op_t;

    typedef enum logic [1:0] {
        alu_reg,
        alu_imm,
        load,
        store
    } op_kind_t;

    typedef enum logic [1:0] {
        from_reg,
        from_mem,
        from_wb
    } fwd_sel_t;

    // one decoded operation as the issuer hands it over
    typedef struct packed {
        op_kind_t kind;
        alu_op_t  alu_op;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        word_t    imm;
    } op_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rs;
        reg_idx_t rt;
        logic     uses_rt;
        logic     is_load;
        reg_idx_t rd;
    } ex_fwd_t;

    typedef struct packed {
        logic     valid;
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } dest_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    // rt is a source for reg-reg ALU ops and as store data
    function automatic logic reads_rt(op_kind_t kind);
        return (kind == alu_reg) || (kind == store);
    endfunction

endpackage

/* verilog/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     issue,
    input  op_t      issued_op,
    input  word_t    issued_rs_data,
    input  word_t    issued_rt_data,

    input  fwd_sel_t a_sel,
    input  fwd_sel_t b_sel,
    input  fwd_sel_t store_sel,
    input  dest_t    wb_dest,

    output ex_fwd_t  ex_fwd,

    output dest_t    mem_dest,
    output logic     mem_is_load,
    output logic     mem_is_store,
    output word_t    mem_addr,
    output word_t    mem_store_data
);

    logic     idex_valid;
    op_t      idex_op;
    word_t    idex_rs_data;
    word_t    idex_rt_data;

    word_t    op_a;
    word_t    op_b;
    word_t    store_val;
    word_t    alu_result;
    alu_op_t  alu_op;

    logic     ex_mem_valid;
    logic     ex_mem_we;
    reg_idx_t ex_mem_rd;
    word_t    ex_mem_result;

    function automatic word_t pick_operand(fwd_sel_t sel, word_t reg_val,
                                           word_t mem_val, word_t wb_val);
        case (sel)
            from_mem: return mem_val;
            from_wb:  return wb_val;
            default:  return reg_val;
        endcase
    endfunction

    // ID/EX, no issue means a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idex_valid <= 1'b0;
        end else begin
            idex_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            idex_op      <= issued_op;
            idex_rs_data <= issued_rs_data;
            idex_rt_data <= issued_rt_data;
        end
    end

    assign ex_fwd = '{valid:   idex_valid,
                      rs:      idex_op.rs,
                      rt:      idex_op.rt,
                      uses_rt: reads_rt(idex_op.kind),
                      is_load: (idex_op.kind == load),
                      rd:      idex_op.rd};

    always_comb begin
        op_a      = pick_operand(a_sel, idex_rs_data, ex_mem_result, wb_dest.data);
        store_val = pick_operand(store_sel, idex_rt_data, ex_mem_result, wb_dest.data);
        if (idex_op.kind == alu_reg) begin
            op_b = pick_operand(b_sel, idex_rt_data, ex_mem_result, wb_dest.data);
        end else begin
            op_b = idex_op.imm;
        end
    end

    // loads and stores use the adder for the address
    assign alu_op = (idex_op.kind == load || idex_op.kind == store) ? alu_add : idex_op.alu_op;

    always_comb begin
        case (alu_op)
            alu_add: alu_result = op_a + op_b;
            alu_sub: alu_result = op_a - op_b;
            alu_and: alu_result = op_a & op_b;
            alu_or:  alu_result = op_a | op_b;
            alu_xor: alu_result = op_a ^ op_b;
            alu_slt: alu_result = word_t'($signed(op_a) < $signed(op_b));
            alu_sll: alu_result = op_a << op_b[SHAMT_WIDTH-1:0];
            alu_srl: alu_result = op_a >> op_b[SHAMT_WIDTH-1:0];
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_valid <= 1'b0;
            ex_mem_we    <= 1'b0;
            mem_is_load  <= 1'b0;
            mem_is_store <= 1'b0;
        end else begin
            ex_mem_valid <= idex_valid;
            ex_mem_we    <= idex_valid && (idex_op.kind != store);
            mem_is_load  <= idex_valid && (idex_op.kind == load);
            mem_is_store <= idex_valid && (idex_op.kind == store);
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_rd      <= idex_op.rd;
        ex_mem_result  <= alu_result;
        mem_store_data <= store_val;
    end

    assign mem_dest = '{valid: ex_mem_valid, we: ex_mem_we, rd: ex_mem_rd, data: ex_mem_result};
    assign mem_addr = ex_mem_result;

endmodule

/* verilog/forwarding_unit.sv */
`timescale 1ns/1ps

module forwarding_unit
    import cpu_pkg::*;
(
    input  ex_fwd_t  ex_fwd,
    input  dest_t    mem_dest,
    input  dest_t    wb_dest,

    output fwd_sel_t a_sel,
    output fwd_sel_t b_sel,
    output fwd_sel_t store_sel
);

    function automatic logic dest_hit(dest_t dest, reg_idx_t src);
        return dest.valid && dest.we && (dest.rd != '0) && (dest.rd == src);
    endfunction

    // younger result in MEM wins over WB
    function automatic fwd_sel_t pick(reg_idx_t src);
        if (!ex_fwd.valid) begin
            return from_reg;
        end
        if (dest_hit(mem_dest, src)) begin
            return from_mem;
        end
        if (dest_hit(wb_dest, src)) begin
            return from_wb;
        end
        return from_reg;
    endfunction

    always_comb begin
        a_sel     = pick(ex_fwd.rs);
        b_sel     = pick(ex_fwd.rt);
        store_sel = pick(ex_fwd.rt);
    end

endmodule

/* verilog/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  dest_t mem_dest,
    input  logic  mem_is_load,
    input  logic  mem_is_store,
    input  word_t mem_addr,
    input  word_t mem_store_data,

    output dest_t wb_dest,
    output logic  wb_valid,
    output wb_t   wb
);

    word_t                      dmem [DMEM_DEPTH];
    logic [DMEM_ADDR_WIDTH-1:0] word_addr;
    word_t                      load_data;

    logic     wb_valid_q;
    logic     wb_we_q;
    reg_idx_t wb_rd_q;
    word_t    wb_data_q;

    // word addressed, upper address bits ignored
    assign word_addr = mem_addr[DMEM_ADDR_WIDTH-1:0];
    assign load_data = dmem[word_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_is_store) begin
            dmem[word_addr] <= mem_store_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_q <= 1'b0;
            wb_we_q    <= 1'b0;
        end else begin
            wb_valid_q <= mem_dest.valid;
            wb_we_q    <= mem_dest.we;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_q   <= mem_dest.rd;
        wb_data_q <= mem_is_load ? load_data : mem_dest.data;
    end

    assign wb_dest = '{valid: wb_valid_q, we: wb_we_q, rd: wb_rd_q, data: wb_data_q};

    // stores carry we low and never report
    assign wb_valid = wb_valid_q && wb_we_q;
    assign wb       = '{rd: wb_rd_q, data: wb_data_q};

endmodule

/* verilog/op_queue.sv */
`timescale 1ns/1ps

module op_queue
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     op_valid,
    input  op_t      op,
    output logic     credit_return,

    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    input  word_t    rs_data,
    input  word_t    rt_data,

    input  ex_fwd_t  ex_fwd,

    output logic     issue,
    output op_t      issued_op,
    output word_t    issued_rs_data,
    output word_t    issued_rt_data
);

    op_t                        entries [QUEUE_DEPTH];
    logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;
    logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;
    logic [CREDIT_WIDTH-1:0]    count;
    op_t                        head;
    logic                       rs_hit;
    logic                       rt_hit;
    logic                       load_use;

    assign head   = entries[rd_ptr];
    assign rs_idx = head.rs;
    assign rt_idx = head.rt;

    // load result not ready before MEM, hold the head one cycle
    assign rs_hit   = (head.rs == ex_fwd.rd);
    assign rt_hit   = reads_rt(head.kind) && (head.rt == ex_fwd.rd);
    assign load_use = ex_fwd.valid && ex_fwd.is_load && (ex_fwd.rd != '0) && (rs_hit || rt_hit);

    assign issue         = (count != '0) && !load_use;
    assign credit_return = issue;

    assign issued_op      = head;
    assign issued_rs_data = rs_data;
    assign issued_rt_data = rt_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (op_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CREDIT_WIDTH'(op_valid) - CREDIT_WIDTH'(issue);
        end
    end

    // issuer holds a credit, so a free slot is guaranteed
    always_ff @(posedge clk) begin
        if (op_valid) begin
            entries[wr_ptr] <= op;
        end
    end

endmodule

/* verilog/register_file.sv */
`timescale 1ns/1ps

module register_file
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rs_data,
    output word_t    rt_data,

    input  dest_t    wb_dest
);

    word_t regs [1:REG_COUNT-1];
    logic  wr_en;

    assign wr_en = wb_dest.valid && wb_dest.we && (wb_dest.rd != '0);

    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        // write-through, same-cycle WB write is visible
        if (wr_en && (wb_dest.rd == idx)) begin
            return wb_dest.data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs_data = read_port(rs_idx);
        rt_data = read_port(rt_idx);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_dest.rd] <= wb_dest.data;
        end
    end

endmodule
